// ==== design/soc_ifc_req_pkg.sv ====
`default_nettype none

package soc_ifc_req_pkg;

    // request field widths
    localparam int SOC_IFC_ADDR_W = 16;
    localparam int SOC_IFC_DATA_W = 32;
    // user attribute carried by soc requests
    localparam int SOC_IFC_USER_W = 32;

    // users allowed into the mailbox window
    localparam int NUM_MBOX_USERS = 5;

    // access type of a request
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_op_e;

    // target access sequencer
    // idle until dv, wait while holding, done for one cycle with hold low
    typedef enum logic [1:0] {
        TGT_IDLE = 2'd0,
        TGT_WAIT = 2'd1,
        TGT_DONE = 2'd2
    } tgt_state_e;

endpackage

`default_nettype wire

// ==== design/soc_ifc_map_pkg.sv ====
`default_nettype none

package soc_ifc_map_pkg;

    // target indices, also the order of the window tables below
    localparam int NUM_TGT  = 3;
    localparam int TGT_MBOX = 0;
    localparam int TGT_SHA  = 1;
    localparam int TGT_REG  = 2;

    // address windows, anything outside is unmapped
    localparam logic [15:0] MBOX_START_ADDR = 16'h0000;
    localparam logic [15:0] MBOX_END_ADDR   = 16'h00FF;
    localparam logic [15:0] SHA_START_ADDR  = 16'h0100;
    localparam logic [15:0] SHA_END_ADDR    = 16'h01FF;
    localparam logic [15:0] REG_START_ADDR  = 16'h0200;
    localparam logic [15:0] REG_END_ADDR    = 16'h02FF;

    localparam logic [15:0] TGT_START_ADDR [NUM_TGT] =
        '{MBOX_START_ADDR, SHA_START_ADDR, REG_START_ADDR};
    localparam logic [15:0] TGT_END_ADDR [NUM_TGT] =
        '{MBOX_END_ADDR, SHA_END_ADDR, REG_END_ADDR};

    // per-target storage, word index from address bits 5:2
    localparam int TGT_WORDS   = 8;
    localparam int TGT_IDX_LSB = 2;
    localparam int TGT_IDX_W   = 4;
    localparam int TGT_SEL_W   = $clog2(TGT_WORDS);

    // cycles a target holds each access
    localparam int TGT_WAIT_CYC = 2;
    localparam int TGT_CNT_W    = $clog2(TGT_WAIT_CYC + 1);

endpackage

`default_nettype wire

// ==== design/soc_ifc_tgt.sv ====
`default_nettype none

module soc_ifc_tgt
    import soc_ifc_req_pkg::*;
    import soc_ifc_map_pkg::*;
#(
    parameter int TGT_ID = 0
) (
    input  logic                      clk,
    input  logic                      rst_b,
    input  logic                      req_dv,
    input  req_op_e                   req_op,
    input  logic [SOC_IFC_ADDR_W-1:0] req_addr,
    input  logic [SOC_IFC_DATA_W-1:0] req_wdata,
    output logic                      req_hold,
    output logic [SOC_IFC_DATA_W-1:0] rdata,
    output logic                      error
);

    tgt_state_e               state;
    logic [TGT_CNT_W-1:0]     wait_cnt;
    logic [TGT_IDX_W-1:0]     word_idx;
    logic [TGT_SEL_W-1:0]     word_sel;
    logic                     idx_ok;
    logic                     done;
    logic                     do_write;
    logic [SOC_IFC_DATA_W-1:0] words [TGT_WORDS];

    // word index, anything past the last word is out of range
    assign word_idx = req_addr[TGT_IDX_LSB +: TGT_IDX_W];
    assign word_sel = word_idx[TGT_SEL_W-1:0];
    assign idx_ok   = word_idx < TGT_IDX_W'(TGT_WORDS);
    assign done     = (state == TGT_DONE);

    // the accepting idle cycle counts as the first wait cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state    <= TGT_IDLE;
            wait_cnt <= '0;
        end else begin
            unique case (state)
                TGT_IDLE: begin
                    if (req_dv) begin
                        wait_cnt <= TGT_CNT_W'(1);
                        state    <= (TGT_WAIT_CYC > 1) ? TGT_WAIT : TGT_DONE;
                    end
                end
                TGT_WAIT: begin
                    if (wait_cnt == TGT_CNT_W'(TGT_WAIT_CYC - 1)) begin
                        state <= TGT_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + TGT_CNT_W'(1);
                    end
                end
                TGT_DONE: begin
                    // a new dv is taken next cycle in idle
                    state    <= TGT_IDLE;
                    wait_cnt <= '0;
                end
                default: begin
                    state <= TGT_IDLE;
                end
            endcase
        end
    end

    // hold from the first dv cycle until done
    assign req_hold = ((state == TGT_IDLE) & req_dv) | (state == TGT_WAIT);

    // storage, word k comes up as TGT_ID*256 + k
    assign do_write = done & idx_ok & (req_op == REQ_WRITE);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int k = 0; k < TGT_WORDS; k++) begin
                words[k] <= SOC_IFC_DATA_W'(TGT_ID * 256 + k);
            end
        end else if (do_write) begin
            words[word_sel] <= req_wdata;
        end
    end

    // response only in the done cycle
    assign rdata = (done & idx_ok & (req_op == REQ_READ)) ? words[word_sel] : '0;
    assign error = done & ~idx_ok;

endmodule

`default_nettype wire

// ==== design/soc_ifc_arb.sv ====
`default_nettype none

module soc_ifc_arb
    import soc_ifc_req_pkg::*;
    import soc_ifc_map_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_b,

    input  logic [NUM_MBOX_USERS-1:0][SOC_IFC_USER_W-1:0] valid_mbox_users,

    // microcontroller requester
    input  logic                                          uc_req_dv,
    input  req_op_e                                       uc_req_op,
    input  logic [SOC_IFC_ADDR_W-1:0]                     uc_req_addr,
    input  logic [SOC_IFC_DATA_W-1:0]                     uc_req_wdata,
    output logic                                          uc_req_hold,
    output logic [SOC_IFC_DATA_W-1:0]                     uc_rdata,
    output logic                                          uc_error,

    // soc bus requester
    input  logic                                          soc_req_dv,
    input  req_op_e                                       soc_req_op,
    input  logic [SOC_IFC_ADDR_W-1:0]                     soc_req_addr,
    input  logic [SOC_IFC_DATA_W-1:0]                     soc_req_wdata,
    input  logic [SOC_IFC_USER_W-1:0]                     soc_req_user,
    output logic                                          soc_req_hold,
    output logic [SOC_IFC_DATA_W-1:0]                     soc_rdata,
    output logic                                          soc_error,

    // targets, indexed by TGT_MBOX / TGT_SHA / TGT_REG
    output logic [NUM_TGT-1:0]                            tgt_req_dv,
    output req_op_e                                       tgt_req_op [NUM_TGT],
    output logic [SOC_IFC_ADDR_W-1:0]                     tgt_req_addr [NUM_TGT],
    output logic [SOC_IFC_DATA_W-1:0]                     tgt_req_wdata [NUM_TGT],
    input  logic [NUM_TGT-1:0]                            tgt_req_hold,
    input  logic [SOC_IFC_DATA_W-1:0]                     tgt_rdata [NUM_TGT],
    input  logic [NUM_TGT-1:0]                            tgt_error
);

    // one-hot target decode per requester
    logic [NUM_TGT-1:0] uc_req;
    logic [NUM_TGT-1:0] soc_req;
    // grants and in-progress flags per target
    logic [NUM_TGT-1:0] uc_gnt;
    logic [NUM_TGT-1:0] soc_gnt;
    logic [NUM_TGT-1:0] uc_ip;
    logic [NUM_TGT-1:0] soc_ip;
    logic [NUM_TGT-1:0] collision;
    // low after reset, so uc wins the first collision
    logic               soc_has_priority;
    logic               soc_user_ok;

    // address inside a window, both bounds included
    function automatic logic in_window(
        input logic [SOC_IFC_ADDR_W-1:0] addr,
        input logic [SOC_IFC_ADDR_W-1:0] lo,
        input logic [SOC_IFC_ADDR_W-1:0] hi
    );
        return (addr >= lo) && (addr <= hi);
    endfunction

    // soc user must match one of the configured mailbox users
    always_comb begin
        soc_user_ok = 1'b0;
        for (int i = 0; i < NUM_MBOX_USERS; i++) begin
            soc_user_ok |= (soc_req_user == valid_mbox_users[i]);
        end
    end

    // address decode
    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            uc_req[t]  = uc_req_dv
                       & in_window(uc_req_addr, TGT_START_ADDR[t], TGT_END_ADDR[t]);
            soc_req[t] = soc_req_dv
                       & in_window(soc_req_addr, TGT_START_ADDR[t], TGT_END_ADDR[t]);
        end
        // a filtered soc mailbox request decodes nowhere and errors out
        soc_req[TGT_MBOX] = soc_req[TGT_MBOX] & soc_user_ok;
    end

    // both sides on one target
    assign collision = uc_req & soc_req;

    // grant by priority on collision
    // an access already held by the target keeps its grant
    always_comb begin
        uc_gnt  = uc_req & ~soc_ip
                & (uc_ip | ~soc_req | {NUM_TGT{~soc_has_priority}});
        soc_gnt = soc_req & ~uc_ip
                & (soc_ip | ~uc_req | {NUM_TGT{soc_has_priority}});
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            soc_has_priority <= 1'b0;
            uc_ip            <= '0;
            soc_ip           <= '0;
        end else begin
            // flips on every collision cycle
            if (|collision) begin
                soc_has_priority <= ~soc_has_priority;
            end
            // granted and held means still in flight next cycle
            uc_ip  <= uc_gnt & tgt_req_hold;
            soc_ip <= soc_gnt & tgt_req_hold;
        end
    end

    // request fields to each target, and/or muxed by grant
    // zero when nobody is granted
    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            tgt_req_dv[t]    = uc_gnt[t] | soc_gnt[t];
            tgt_req_op[t]    = req_op_e'((uc_gnt[t] & uc_req_op)
                                       | (soc_gnt[t] & soc_req_op));
            tgt_req_addr[t]  = ({SOC_IFC_ADDR_W{uc_gnt[t]}} & uc_req_addr)
                             | ({SOC_IFC_ADDR_W{soc_gnt[t]}} & soc_req_addr);
            tgt_req_wdata[t] = ({SOC_IFC_DATA_W{uc_gnt[t]}} & uc_req_wdata)
                             | ({SOC_IFC_DATA_W{soc_gnt[t]}} & soc_req_wdata);
        end
    end

    // read data back by decode, decode is one-hot per requester
    always_comb begin
        uc_rdata  = '0;
        soc_rdata = '0;
        for (int t = 0; t < NUM_TGT; t++) begin
            uc_rdata  |= {SOC_IFC_DATA_W{uc_req[t]}} & tgt_rdata[t];
            soc_rdata |= {SOC_IFC_DATA_W{soc_req[t]}} & tgt_rdata[t];
        end
    end

    // hold while waiting for the grant or while the target holds
    assign uc_req_hold  = |(uc_req & (~uc_gnt | tgt_req_hold));
    assign soc_req_hold = |(soc_req & (~soc_gnt | tgt_req_hold));

    // target error on the granted side, or nothing decoded at all
    assign uc_error  = |(uc_gnt & tgt_error) | (uc_req_dv & ~|uc_req);
    assign soc_error = |(soc_gnt & tgt_error) | (soc_req_dv & ~|soc_req);

endmodule

`default_nettype wire

// ==== design/soc_ifc_top.sv ====
`default_nettype none

module soc_ifc_top
    import soc_ifc_req_pkg::*;
    import soc_ifc_map_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_b,

    input  logic [NUM_MBOX_USERS-1:0][SOC_IFC_USER_W-1:0] valid_mbox_users,

    // microcontroller port
    input  logic                                          uc_req_dv,
    input  req_op_e                                       uc_req_op,
    input  logic [SOC_IFC_ADDR_W-1:0]                     uc_req_addr,
    input  logic [SOC_IFC_DATA_W-1:0]                     uc_req_wdata,
    output logic                                          uc_req_hold,
    output logic [SOC_IFC_DATA_W-1:0]                     uc_rdata,
    output logic                                          uc_error,

    // soc bus port
    input  logic                                          soc_req_dv,
    input  req_op_e                                       soc_req_op,
    input  logic [SOC_IFC_ADDR_W-1:0]                     soc_req_addr,
    input  logic [SOC_IFC_DATA_W-1:0]                     soc_req_wdata,
    input  logic [SOC_IFC_USER_W-1:0]                     soc_req_user,
    output logic                                          soc_req_hold,
    output logic [SOC_IFC_DATA_W-1:0]                     soc_rdata,
    output logic                                          soc_error
);

    // arbiter to target wiring
    logic [NUM_TGT-1:0]        tgt_req_dv;
    req_op_e                   tgt_req_op [NUM_TGT];
    logic [SOC_IFC_ADDR_W-1:0] tgt_req_addr [NUM_TGT];
    logic [SOC_IFC_DATA_W-1:0] tgt_req_wdata [NUM_TGT];
    logic [NUM_TGT-1:0]        tgt_req_hold;
    logic [SOC_IFC_DATA_W-1:0] tgt_rdata [NUM_TGT];
    logic [NUM_TGT-1:0]        tgt_error;

    soc_ifc_arb u_arb (
        .clk              (clk),
        .rst_b            (rst_b),
        .valid_mbox_users (valid_mbox_users),
        .uc_req_dv        (uc_req_dv),
        .uc_req_op        (uc_req_op),
        .uc_req_addr      (uc_req_addr),
        .uc_req_wdata     (uc_req_wdata),
        .uc_req_hold      (uc_req_hold),
        .uc_rdata         (uc_rdata),
        .uc_error         (uc_error),
        .soc_req_dv       (soc_req_dv),
        .soc_req_op       (soc_req_op),
        .soc_req_addr     (soc_req_addr),
        .soc_req_wdata    (soc_req_wdata),
        .soc_req_user     (soc_req_user),
        .soc_req_hold     (soc_req_hold),
        .soc_rdata        (soc_rdata),
        .soc_error        (soc_error),
        .tgt_req_dv       (tgt_req_dv),
        .tgt_req_op       (tgt_req_op),
        .tgt_req_addr     (tgt_req_addr),
        .tgt_req_wdata    (tgt_req_wdata),
        .tgt_req_hold     (tgt_req_hold),
        .tgt_rdata        (tgt_rdata),
        .tgt_error        (tgt_error)
    );

    // mailbox, sha and control windows, same bank with its own reset words
    for (genvar t = 0; t < NUM_TGT; t++) begin : g_tgt
        soc_ifc_tgt #(
            .TGT_ID (t)
        ) u_tgt (
            .clk       (clk),
            .rst_b     (rst_b),
            .req_dv    (tgt_req_dv[t]),
            .req_op    (tgt_req_op[t]),
            .req_addr  (tgt_req_addr[t]),
            .req_wdata (tgt_req_wdata[t]),
            .req_hold  (tgt_req_hold[t]),
            .rdata     (tgt_rdata[t]),
            .error     (tgt_error[t])
        );
    end

endmodule

`default_nettype wire

// ==== testbench/soc_ifc_props.sv ====
`default_nettype none

module soc_ifc_props
    import soc_ifc_req_pkg::*;
    import soc_ifc_map_pkg::*;
(
    input logic                                          clk,
    input logic                                          rst_b,
    input logic [NUM_MBOX_USERS-1:0][SOC_IFC_USER_W-1:0] valid_mbox_users,
    input logic [SOC_IFC_USER_W-1:0]                     soc_req_user,
    input logic [NUM_TGT-1:0]                            uc_gnt,
    input logic [NUM_TGT-1:0]                            soc_gnt,
    input logic [NUM_TGT-1:0]                            tgt_req_hold,
    input logic [NUM_TGT-1:0]                            tgt_req_dv
);
    timeunit 1ns;
    timeprecision 100ps;

    logic user_listed;

    // soc user against the configured list
    always_comb begin
        user_listed = 1'b0;
        for (int i = 0; i < NUM_MBOX_USERS; i++) begin
            if (soc_req_user == valid_mbox_users[i]) user_listed = 1'b1;
        end
    end

    // one owner per target for the whole access
    // a target held for one side last cycle is not handed to the other
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_b)
        ((uc_gnt & soc_gnt)
         | (uc_gnt & $past(soc_gnt & tgt_req_hold))
         | (soc_gnt & $past(uc_gnt & tgt_req_hold))) == '0)
        else $error("target granted to both requesters");

    // targets see nothing while in reset
    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_b |-> tgt_req_dv == '0)
        else $error("target request during reset");

    a_mbox_user: assert property (@(posedge clk) disable iff (!rst_b)
        soc_gnt[TGT_MBOX] |-> user_listed)
        else $error("soc mailbox grant with unlisted user");

endmodule

bind soc_ifc_arb soc_ifc_props u_props (
    .clk              (clk),
    .rst_b            (rst_b),
    .valid_mbox_users (valid_mbox_users),
    .soc_req_user     (soc_req_user),
    .uc_gnt           (uc_gnt),
    .soc_gnt          (soc_gnt),
    .tgt_req_hold     (tgt_req_hold),
    .tgt_req_dv       (tgt_req_dv)
);

`default_nettype wire

// ==== testbench/soc_ifc_tb.sv ====
`default_nettype none

module soc_ifc_tb
    import soc_ifc_req_pkg::*;
    import soc_ifc_map_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 4;
    localparam int ROW_CYCLES = 40;
    // who issues a row
    localparam logic [1:0] FROM_UC   = 2'd0;
    localparam logic [1:0] FROM_SOC  = 2'd1;
    localparam logic [1:0] FROM_BOTH = 2'd2;
    localparam logic [31:0] GOOD_USER = 32'h4444_0004;
    localparam logic [31:0] BAD_USER  = 32'h4444_0005;
    localparam int WT = TGT_WAIT_CYC;

    typedef struct {
        logic [1:0]  who;
        req_op_e     op;
        logic [15:0] uc_addr;
        logic [15:0] soc_addr;
        logic [31:0] user;
        logic        exp_err;
        // cycles from dv to completion, -1 when order is not fixed
        int          exp_lat;
    } row_t;

    logic clk;
    logic rst_b;
    logic [NUM_MBOX_USERS-1:0][SOC_IFC_USER_W-1:0] valid_mbox_users;
    logic uc_req_dv, uc_req_hold, uc_error;
    req_op_e uc_req_op;
    logic [SOC_IFC_ADDR_W-1:0] uc_req_addr;
    logic [SOC_IFC_DATA_W-1:0] uc_req_wdata, uc_rdata;
    logic soc_req_dv, soc_req_hold, soc_error;
    req_op_e soc_req_op;
    logic [SOC_IFC_ADDR_W-1:0] soc_req_addr;
    logic [SOC_IFC_DATA_W-1:0] soc_req_wdata, soc_rdata;
    logic [SOC_IFC_USER_W-1:0] soc_req_user;

    row_t        rows[$];
    logic [31:0] shadow [NUM_TGT][TGT_WORDS];
    logic [31:0] lcg_state = 32'hb077_b54f;
    int          errors = 0;
    int          cycle_cnt = 0;
    int          cycle_limit;
    // results captured at completion
    logic [31:0] uc_got, soc_got;
    logic        uc_err_got, soc_err_got;
    int          uc_lat, soc_lat;

    soc_ifc_top dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // storage model, target from address bits 15:8, word from bits 5:2
    function automatic logic [31:0] model_read(input logic [15:0] addr);
        return shadow[int'(addr[15:8])][int'(addr[5:2])];
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [31:0] d);
        shadow[int'(addr[15:8])][int'(addr[5:2])] = d;
    endfunction

    function automatic void add_row(input logic [1:0] who, input req_op_e op,
                                    input logic [15:0] ua, input logic [15:0] sa,
                                    input logic [31:0] user, input logic err, input int lat);
        row_t r;
        r = '{who, op, ua, sa, user, err, lat};
        rows.push_back(r);
    endfunction

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("MISMATCH %s actual=%h expected=%h", name, act, exp);
            errors++;
        end
    endtask

    // drive one access and wait for dv high with hold low
    task automatic access(input bit is_soc, input req_op_e op, input logic [15:0] addr,
                          input logic [31:0] wdata, input logic [31:0] user,
                          output logic [31:0] rdata, output logic err, output int lat);
        @(posedge clk);
        if (is_soc) begin
            soc_req_dv    <= 1'b1;
            soc_req_op    <= op;
            soc_req_addr  <= addr;
            soc_req_wdata <= wdata;
            soc_req_user  <= user;
        end else begin
            uc_req_dv    <= 1'b1;
            uc_req_op    <= op;
            uc_req_addr  <= addr;
            uc_req_wdata <= wdata;
        end
        lat = 0;
        // outputs are settled by the falling edge
        @(negedge clk);
        while (is_soc ? soc_req_hold : uc_req_hold) begin
            lat++;
            @(negedge clk);
        end
        rdata = is_soc ? soc_rdata : uc_rdata;
        err   = is_soc ? soc_error : uc_error;
        @(posedge clk);
        if (is_soc) soc_req_dv <= 1'b0;
        else uc_req_dv <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] uc_wd, soc_wd, uc_exp, soc_exp;
        uc_wd     = lcg_state;
        soc_wd    = lcg_next(lcg_state);
        lcg_state = lcg_next(soc_wd);
        // expected read data before this row changes the model
        uc_exp  = (r.op == REQ_READ && !r.exp_err) ? model_read(r.uc_addr) : '0;
        soc_exp = (r.op == REQ_READ && !r.exp_err) ? model_read(r.soc_addr) : '0;
        fork
            begin
                if (r.who != FROM_SOC)
                    access(1'b0, r.op, r.uc_addr, uc_wd, '0, uc_got, uc_err_got, uc_lat);
            end
            begin
                if (r.who != FROM_UC)
                    access(1'b1, r.op, r.soc_addr, soc_wd, r.user, soc_got, soc_err_got, soc_lat);
            end
        join
        if (r.who != FROM_SOC) begin
            check_value("uc_rdata", uc_got, uc_exp);
            check_value("uc_error", 32'(uc_err_got), 32'(r.exp_err));
            if (r.exp_lat >= 0) check_value("uc_latency", 32'(uc_lat), 32'(r.exp_lat));
            if (r.op == REQ_WRITE && !r.exp_err) model_write(r.uc_addr, uc_wd);
        end
        if (r.who != FROM_UC) begin
            check_value("soc_rdata", soc_got, soc_exp);
            check_value("soc_error", 32'(soc_err_got), 32'(r.exp_err));
            if (r.exp_lat >= 0) check_value("soc_latency", 32'(soc_lat), 32'(r.exp_lat));
            if (r.op == REQ_WRITE && !r.exp_err) model_write(r.soc_addr, soc_wd);
        end
        // collision winner sees the plain wait
        // the loser also waits out the winner and its done cycle
        if (r.who == FROM_BOTH && r.exp_lat < 0) begin
            check_value("first_latency",
                        32'((uc_lat < soc_lat) ? uc_lat : soc_lat), 32'(WT));
            check_value("second_latency",
                        32'((uc_lat < soc_lat) ? soc_lat : uc_lat), 32'(2 * WT + 1));
        end
    endtask

    // run limit from the table length
    initial begin
        @(posedge clk);
        cycle_limit = rows.size() * ROW_CYCLES + RST_CYCLES;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk <= 1'b0;
        rst_b <= 1'b0;
        valid_mbox_users <= {32'h5555_0005, 32'h4444_0004, 32'h3333_0003,
                             32'h2222_0002, 32'h1111_0001};
        uc_req_dv <= 1'b0;
        uc_req_op <= REQ_READ;
        uc_req_addr <= '0;
        uc_req_wdata <= '0;
        soc_req_dv <= 1'b0;
        soc_req_op <= REQ_READ;
        soc_req_addr <= '0;
        soc_req_wdata <= '0;
        soc_req_user <= '0;
        for (int t = 0; t < NUM_TGT; t++)
            for (int k = 0; k < TGT_WORDS; k++)
                shadow[t][k] = 32'(t * 256 + k);
        // reset words of all windows
        add_row(FROM_UC, REQ_READ, 16'h0000, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h001C, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h0100, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h011C, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h0200, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h021C, 16'h0000, GOOD_USER, 1'b0, WT);
        // write on one side, read back on the other
        add_row(FROM_UC, REQ_WRITE, 16'h0004, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_READ, 16'h0000, 16'h0004, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_WRITE, 16'h0000, 16'h0108, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h0108, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_WRITE, 16'h0214, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_READ, 16'h0000, 16'h0214, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_WRITE, 16'h0000, 16'h0018, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h0018, 16'h0000, GOOD_USER, 1'b0, WT);
        // unmapped errors at once, out-of-range words at completion
        add_row(FROM_UC, REQ_READ, 16'h0300, 16'h0000, GOOD_USER, 1'b1, 0);
        add_row(FROM_SOC, REQ_WRITE, 16'h0000, 16'hF000, GOOD_USER, 1'b1, 0);
        add_row(FROM_UC, REQ_WRITE, 16'h0120, 16'h0000, GOOD_USER, 1'b1, WT);
        add_row(FROM_UC, REQ_READ, 16'h0100, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_READ, 16'h0000, 16'h023C, GOOD_USER, 1'b1, WT);
        add_row(FROM_SOC, REQ_READ, 16'h0000, 16'h0200, GOOD_USER, 1'b0, WT);
        // mailbox user filter
        add_row(FROM_SOC, REQ_WRITE, 16'h0000, 16'h000C, BAD_USER, 1'b1, 0);
        add_row(FROM_UC, REQ_READ, 16'h000C, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_WRITE, 16'h0000, 16'h000C, GOOD_USER, 1'b0, WT);
        add_row(FROM_UC, REQ_READ, 16'h000C, 16'h0000, GOOD_USER, 1'b0, WT);
        // same target collides, different targets run in parallel
        add_row(FROM_BOTH, REQ_WRITE, 16'h0204, 16'h0208, GOOD_USER, 1'b0, -1);
        add_row(FROM_UC, REQ_READ, 16'h0208, 16'h0000, GOOD_USER, 1'b0, WT);
        add_row(FROM_SOC, REQ_READ, 16'h0000, 16'h0204, GOOD_USER, 1'b0, WT);
        add_row(FROM_BOTH, REQ_READ, 16'h0204, 16'h0208, GOOD_USER, 1'b0, -1);
        add_row(FROM_BOTH, REQ_WRITE, 16'h0010, 16'h0110, GOOD_USER, 1'b0, WT);
        add_row(FROM_BOTH, REQ_READ, 16'h0110, 16'h0010, GOOD_USER, 1'b0, WT);
        repeat (RST_CYCLES) @(posedge clk);
        rst_b <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end
        $display("%0d rows run, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/soc_ifc_req_pkg.sv
design/soc_ifc_map_pkg.sv
design/soc_ifc_tgt.sv
design/soc_ifc_arb.sv
design/soc_ifc_top.sv
testbench/soc_ifc_props.sv
testbench/soc_ifc_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the soc_ifc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module soc_ifc_tb -f build.f -o soc_ifc_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/soc_ifc_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
